/* Bender.yml */
package:
  name: dwn_read

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dwn_pkg.sv
      - hw/dwn_ar_decode.sv
      - hw/dwn_r_gather.sv
      - hw/dwn_r_dispatch.sv
      - hw/dwn_read_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/dwn_read_chk.sv
      - sim/tb_dwn_read.sv

/* hw/dwn_ar_decode.sv */
// Read request translation from the wide slave port to the narrow master port.
// Purely combinational, handshake passes straight through.

`timescale 1ns/1ps

`include "dwn_defs.svh"

module dwn_ar_decode
(
    // Wide side request
    input  dwn_pkg::ar_req_t slv_ar_i,
    input  logic             slv_ar_valid_i,
    output logic             slv_ar_ready_o,

    // Narrow side request
    output dwn_pkg::ar_req_t mst_ar_o,
    output logic             mst_ar_valid_o,
    input  logic             mst_ar_ready_i
);

    import dwn_pkg::*;

    // Byte offset bits of one wide beat
    localparam int unsigned wide_off_w   = $clog2(`DWN_WIDE_DATA_WIDTH / 8);
    // Size code of one narrow beat
    localparam int unsigned narrow_size  = $clog2(`DWN_NARROW_DATA_WIDTH / 8);

    // Mask clearing the wide beat offset
    localparam addr_t align_mask = ~addr_t'((1 << wide_off_w) - 1);

    // Handshake passes through, back-pressure included
    assign mst_ar_valid_o = slv_ar_valid_i;
    assign slv_ar_ready_o = mst_ar_ready_i;

    always_comb
    begin
        // Burst, id and user copied as they are
        mst_ar_o = slv_ar_i;

        // Every wide beat becomes RATIO narrow beats
        mst_ar_o.len = axi_len_t'((int'(slv_ar_i.len) + 1) * `DWN_RATIO - 1);

        // Narrow bus is always used at full width
        mst_ar_o.size = axi_size_t'(narrow_size);

        // Start on a wide boundary so gathering begins at word 0
        mst_ar_o.addr = slv_ar_i.addr & align_mask;
    end

endmodule

/* hw/dwn_defs.svh */
// Widths, beat ratio and response codes of the read downsizer.
// Included by the package and by any module that needs a raw width.

`ifndef DWN_DEFS_SVH
`define DWN_DEFS_SVH

// Bus widths
`define DWN_ADDR_WIDTH        32
`define DWN_WIDE_DATA_WIDTH   128
`define DWN_NARROW_DATA_WIDTH 64

// Narrow beats per wide beat
`define DWN_RATIO             2

// Side-band widths
`define DWN_ID_WIDTH          3
`define DWN_USER_WIDTH        6

// AXI response codes, larger code is the worse result
`define DWN_RESP_OKAY         2'b00
`define DWN_RESP_EXOKAY       2'b01
`define DWN_RESP_SLVERR       2'b10
`define DWN_RESP_DECERR       2'b11

`endif

/* hw/dwn_pkg.sv */
// Types shared by the read downsizer and its testbench.
// Modules import it inside their body and use scoped names on ports.

`include "dwn_defs.svh"

package dwn_pkg;

    //////////////////////////////
    // Plain vector types
    //////////////////////////////
    typedef logic [`DWN_ADDR_WIDTH-1:0]        addr_t;
    typedef logic [7:0]                        axi_len_t;
    typedef logic [2:0]                        axi_size_t;
    typedef logic [1:0]                        axi_burst_t;
    typedef logic [`DWN_WIDE_DATA_WIDTH-1:0]   wide_data_t;
    typedef logic [`DWN_NARROW_DATA_WIDTH-1:0] narrow_data_t;
    typedef logic [`DWN_ID_WIDTH-1:0]          id_t;
    typedef logic [`DWN_USER_WIDTH-1:0]        user_t;
    typedef logic [1:0]                        resp_t;
    // Narrow word index inside a wide beat
    typedef logic [$clog2(`DWN_RATIO)-1:0]     word_sel_t;

    //////////////////////////////
    // Channel payloads
    //////////////////////////////
    // Read request, same layout on both sides
    typedef struct packed {
        addr_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        id_t        id;
        user_t      user;
    } ar_req_t;

    // Read beat from the narrow master port
    typedef struct packed {
        narrow_data_t data;
        resp_t        resp;
        logic         last;
        id_t          id;
        user_t        user;
    } narrow_r_t;

    // Read beat toward the wide slave port
    typedef struct packed {
        wide_data_t data;
        resp_t      resp;
        logic       last;
        id_t        id;
        user_t      user;
    } wide_r_t;

    // Collector states
    typedef enum logic {
        GATHER,
        FULL
    } gather_state_e;

endpackage

/* hw/dwn_r_dispatch.sv */
// One-entry output register toward the wide slave port.
// Lets the next wide beat be gathered while the slave stalls.

`timescale 1ns/1ps

module dwn_r_dispatch
(
    input  logic              clk_i,
    input  logic              rst_ni,

    // Wide beat from the collector
    input  dwn_pkg::wide_r_t  gather_beat_i,
    input  logic              gather_valid_i,
    output logic              gather_ready_o,

    // Wide read channel of the slave port
    output dwn_pkg::wide_r_t  slv_r_o,
    output logic              slv_r_valid_o,
    input  logic              slv_r_ready_i
);

    import dwn_pkg::*;

    logic    full_q;
    wide_r_t beat_q;
    logic    load;

    // Free when empty or draining this cycle
    assign gather_ready_o = ~full_q | slv_r_ready_i;
    assign load           = gather_valid_i & gather_ready_o;

    //////////////////////////////
    // Occupied flag
    //////////////////////////////
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            full_q <= 1'b0;
        else if (load)
            full_q <= 1'b1;
        // Drained with nothing behind it
        else if (slv_r_ready_i)
            full_q <= 1'b0;
    end

    // Holding register, written only on a transfer from the collector
    always_ff @(posedge clk_i)
    begin
        if (load)
            beat_q <= gather_beat_i;
    end

    assign slv_r_valid_o = full_q;
    assign slv_r_o       = beat_q;

endmodule

/* hw/dwn_r_gather.sv */
// Collects narrow read beats into one wide beat.
// First narrow beat lands in the low word; worst response wins;
// id, user and last come from the final narrow beat.

`timescale 1ns/1ps

`include "dwn_defs.svh"

module dwn_r_gather
(
    input  logic                clk_i,
    input  logic                rst_ni,

    // Narrow read beats from the master port
    input  dwn_pkg::narrow_r_t  mst_r_i,
    input  logic                mst_r_valid_i,
    output logic                mst_r_ready_o,

    // Completed wide beat toward dispatch
    output dwn_pkg::wide_r_t    gather_beat_o,
    output logic                gather_valid_o,
    input  logic                gather_ready_i
);

    import dwn_pkg::*;

    gather_state_e state_q, state_d;
    word_sel_t     word_sel_q, word_sel_d;

    // Payload of the wide beat under construction
    narrow_data_t [`DWN_RATIO-1:0] words_q;
    resp_t                         resp_q;
    logic                          last_q;
    id_t                           id_q;
    user_t                         user_q;

    logic beat_fire;
    logic out_fire;
    logic last_word;

    assign beat_fire = mst_r_valid_i & mst_r_ready_o;
    assign out_fire  = gather_valid_o & gather_ready_i;
    assign last_word = (word_sel_q == word_sel_t'(`DWN_RATIO - 1));

    //////////////////////////////
    // Control
    //////////////////////////////
    always_comb
    begin
        state_d    = state_q;
        word_sel_d = word_sel_q;

        case (state_q)
            GATHER:
            begin
                mst_r_ready_o  = 1'b1;
                gather_valid_o = 1'b0;
            end
            // Accept again only on the handover cycle
            default:
            begin
                mst_r_ready_o  = gather_ready_i;
                gather_valid_o = 1'b1;
            end
        endcase

        if (out_fire)
            state_d = GATHER;

        if (beat_fire)
        begin
            if (last_word)
            begin
                state_d    = FULL;
                word_sel_d = '0;
            end
            else
            begin
                word_sel_d = word_sel_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q    <= GATHER;
            word_sel_q <= '0;
        end
        else
        begin
            state_q    <= state_d;
            word_sel_q <= word_sel_d;
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////
    always_ff @(posedge clk_i)
    begin
        if (beat_fire)
        begin
            words_q[word_sel_q] <= mst_r_i.data;
            // Word 0 restarts the merge, later words keep the worse code
            if (word_sel_q == '0 || mst_r_i.resp > resp_q)
                resp_q <= mst_r_i.resp;
            last_q <= mst_r_i.last;
            id_q   <= mst_r_i.id;
            user_q <= mst_r_i.user;
        end
    end

    assign gather_beat_o.data = wide_data_t'(words_q);
    assign gather_beat_o.resp = resp_q;
    assign gather_beat_o.last = last_q;
    assign gather_beat_o.id   = id_q;
    assign gather_beat_o.user = user_q;

endmodule

/* hw/dwn_read_top.sv */
// Read half of a 128 to 64 bit AXI downsizer.
// AR decode, narrow beat gathering and wide beat dispatch.

`timescale 1ns/1ps

module dwn_read_top
(
    input  logic               clk_i,
    input  logic               rst_ni,

    // Wide slave port
    input  dwn_pkg::ar_req_t   slv_ar_i,
    input  logic               slv_ar_valid_i,
    output logic               slv_ar_ready_o,
    output dwn_pkg::wide_r_t   slv_r_o,
    output logic               slv_r_valid_o,
    input  logic               slv_r_ready_i,

    // Narrow master port
    output dwn_pkg::ar_req_t   mst_ar_o,
    output logic               mst_ar_valid_o,
    input  logic               mst_ar_ready_i,
    input  dwn_pkg::narrow_r_t mst_r_i,
    input  logic               mst_r_valid_i,
    output logic               mst_r_ready_o
);

    import dwn_pkg::*;

    // Collector to dispatch
    wide_r_t gather_beat;
    logic    gather_valid;
    logic    gather_ready;

    // Request translation
    dwn_ar_decode u_ar_decode (
        .slv_ar_i       (slv_ar_i),
        .slv_ar_valid_i (slv_ar_valid_i),
        .slv_ar_ready_o (slv_ar_ready_o),
        .mst_ar_o       (mst_ar_o),
        .mst_ar_valid_o (mst_ar_valid_o),
        .mst_ar_ready_i (mst_ar_ready_i)
    );

    // Narrow beats into wide beats
    dwn_r_gather u_r_gather (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .mst_r_i        (mst_r_i),
        .mst_r_valid_i  (mst_r_valid_i),
        .mst_r_ready_o  (mst_r_ready_o),
        .gather_beat_o  (gather_beat),
        .gather_valid_o (gather_valid),
        .gather_ready_i (gather_ready)
    );

    // Output register toward the slave port
    dwn_r_dispatch u_r_dispatch (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .gather_beat_i  (gather_beat),
        .gather_valid_i (gather_valid),
        .gather_ready_o (gather_ready),
        .slv_r_o        (slv_r_o),
        .slv_r_valid_o  (slv_r_valid_o),
        .slv_r_ready_i  (slv_r_ready_i)
    );

endmodule

/* project.f */
+incdir+hw
hw/dwn_pkg.sv
hw/dwn_ar_decode.sv
hw/dwn_r_gather.sv
hw/dwn_r_dispatch.sv
hw/dwn_read_top.sv
sim/dwn_read_chk.sv
sim/tb_dwn_read.sv

/* sim/dwn_read_chk.sv */
// Protocol assertions for the read downsizer.
// Bound into the top level by the testbench.

`timescale 1ns/1ps

module dwn_read_chk
(
    input logic              clk_i,
    input logic              rst_ni,
    input logic              slv_ar_valid_i,
    input logic              mst_ar_valid_o,
    input dwn_pkg::wide_r_t  slv_r_o,
    input logic              slv_r_valid_o,
    input logic              slv_r_ready_i
);

    import dwn_pkg::*;

    // Running count of failed assertions
    int unsigned fail_count = 0;

    // Stalled wide beat keeps valid and payload
    property r_hold_p;
        @(posedge clk_i) disable iff (!rst_ni)
        slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o && $stable(slv_r_o);
    endproperty

    assert property (r_hold_p)
    else
    begin
        fail_count++;
        $error("Wide read beat dropped or changed before its transfer");
    end

    // AR valid passes straight through
    assert property (@(posedge clk_i) mst_ar_valid_o == slv_ar_valid_i)
    else
    begin
        fail_count++;
        $error("Narrow AR valid differs from wide AR valid");
    end

    // No wide beat during reset
    assert property (@(posedge clk_i) !rst_ni |-> !slv_r_valid_o)
    else
    begin
        fail_count++;
        $error("Wide read valid high during reset");
    end

endmodule

/* sim/tb_dwn_read.sv */
// Directed testbench for the read downsizer.
// Plays the narrow responder and the wide requester, checks every beat.

`timescale 1ns/1ps

`include "dwn_defs.svh"

module tb_dwn_read;

    import dwn_pkg::*;

    localparam int n_tests     = 5;
    localparam int watchdog_ns = n_tests * 200 * 100;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    ar_req_t    slv_ar_i;
    logic       slv_ar_valid_i;
    logic       slv_ar_ready_o;
    wide_r_t    slv_r_o;
    logic       slv_r_valid_o;
    logic       slv_r_ready_i;
    ar_req_t    mst_ar_o;
    logic       mst_ar_valid_o;
    logic       mst_ar_ready_i;
    narrow_r_t  mst_r_i;
    logic       mst_r_valid_i;
    logic       mst_r_ready_o;

    int         cyc;
    int         checks;
    int         errors;
    int         sva_errors;
    integer     seed;
    // Narrow beats the responder returns, in order
    narrow_r_t  beats[$];

    dwn_read_top u_dut (.*);

    bind dwn_read_top dwn_read_chk u_chk (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .slv_ar_valid_i (slv_ar_valid_i),
        .mst_ar_valid_o (mst_ar_valid_o),
        .slv_r_o        (slv_r_o),
        .slv_r_valid_o  (slv_r_valid_o),
        .slv_r_ready_i  (slv_r_ready_i)
    );

    always #50 clk_i = ~clk_i;

    // Cycle counter for latency checks
    always @(posedge clk_i)
        cyc <= cyc + 1;

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_ar(input string name, input ar_req_t exp, input ar_req_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_r(input string name, input wide_r_t exp, input wide_r_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Known narrow beat, id and user differ per beat
    function automatic narrow_r_t known_beat(input int k, input int n);
        narrow_r_t b;
        b.data = {32'hcafe_0000 + k, 32'h0bad_0000 + k};
        b.resp = `DWN_RESP_OKAY;
        b.last = (k == n - 1);
        b.id   = id_t'(k + 1);
        b.user = user_t'(k * 5 + 2);
        return b;
    endfunction

    // First beat low, worst response, side-band of the second beat
    function automatic wide_r_t pair_to_wide(input narrow_r_t lo, input narrow_r_t hi);
        wide_r_t w;
        w.data = {hi.data, lo.data};
        w.resp = (hi.resp > lo.resp) ? hi.resp : lo.resp;
        w.last = hi.last;
        w.id   = hi.id;
        w.user = hi.user;
        return w;
    endfunction

    // Plays the queued beats and checks every wide beat and mst_r_ready_o
    task automatic stream_burst(input string name, input bit stall, input bit check_lat);
        wide_r_t exp_q[$];
        int      acc_q[$];
        int      i;
        int      sent;
        int      got;
        int      pending;
        int      acc;
        for (i = 0; i + 1 < beats.size(); i += 2)
            exp_q.push_back(pair_to_wide(beats[i], beats[i + 1]));
        sent    = 0;
        got     = 0;
        pending = 0;
        while (got < exp_q.size())
        begin
            @(posedge clk_i);
            #10;
            // Index only moves on a transfer, so valid and payload hold
            mst_r_valid_i = (sent < beats.size());
            if (sent < beats.size())
                mst_r_i = beats[sent];
            slv_r_ready_i = stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(negedge clk_i);
            // Stalls only with two wide beats pending and the slave stalling
            check_bit({name, " mst_r_ready"}, (pending < 2) || slv_r_ready_i, mst_r_ready_o);
            if (mst_r_valid_i && mst_r_ready_o)
            begin
                if (sent % `DWN_RATIO == `DWN_RATIO - 1)
                begin
                    acc_q.push_back(cyc);
                    pending++;
                end
                sent++;
            end
            if (slv_r_valid_o && slv_r_ready_i)
            begin
                if (acc_q.size() == 0)
                begin
                    errors++;
                    $display("%s: wide beat issued before its narrow beats arrived", name);
                end
                else
                begin
                    acc = acc_q.pop_front();
                    check_r(name, exp_q[got], slv_r_o);
                    // Final narrow accept, one cycle in the collector, then out
                    if (check_lat)
                        check_bit({name, " latency"}, 1'b1, cyc == acc + 2);
                end
                got++;
                pending--;
            end
        end
        // Nothing more may come out
        repeat (3)
        begin
            @(posedge clk_i);
            #10;
            mst_r_valid_i = 1'b0;
            slv_r_ready_i = 1'b1;
            @(negedge clk_i);
            check_bit({name, " no extra beat"}, 1'b0, slv_r_valid_o);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic reset_state();
        @(negedge clk_i);
        check_bit("reset slv_r_valid", 1'b0, slv_r_valid_o);
        check_bit("reset mst_r_ready", 1'b1, mst_r_ready_o);
    endtask

    task automatic request_translation();
        ar_req_t req;
        ar_req_t exp;
        int      k;
        for (k = 0; k < 20; k++)
        begin
            req.addr  = addr_t'($random(seed));
            req.len   = axi_len_t'($random(seed)) & 8'h7f;
            req.size  = 3'd4;
            req.burst = 2'b01;
            req.id    = id_t'($random(seed));
            req.user  = user_t'($random(seed));
            exp       = req;
            exp.addr  = {req.addr[`DWN_ADDR_WIDTH-1:4], 4'h0};
            // Two narrow beats per wide beat, so 2 * len + 1
            exp.len   = {req.len[6:0], 1'b1};
            exp.size  = 3'd3;
            // Master stalls first, then accepts
            @(posedge clk_i);
            #10;
            slv_ar_i       = req;
            slv_ar_valid_i = 1'b1;
            mst_ar_ready_i = 1'b0;
            @(negedge clk_i);
            check_ar("ar translate", exp, mst_ar_o);
            check_bit("ar valid high", 1'b1, mst_ar_valid_o);
            check_bit("ar ready low", 1'b0, slv_ar_ready_o);
            @(posedge clk_i);
            #10;
            mst_ar_ready_i = 1'b1;
            @(negedge clk_i);
            check_ar("ar translate held", exp, mst_ar_o);
            check_bit("ar ready high", 1'b1, slv_ar_ready_o);
        end
        @(posedge clk_i);
        #10;
        slv_ar_valid_i = 1'b0;
        mst_ar_ready_i = 1'b0;
        @(negedge clk_i);
        check_bit("ar valid low", 1'b0, mst_ar_valid_o);
    endtask

    task automatic gather_plain();
        int k;
        beats.delete();
        for (k = 0; k < 4; k++)
            beats.push_back(known_beat(k, 4));
        stream_burst("gather", 1'b0, 1'b1);
    endtask

    task automatic slave_backpressure();
        narrow_r_t b;
        int        k;
        beats.delete();
        for (k = 0; k < 8; k++)
        begin
            b      = known_beat(k, 8);
            b.data = {$random(seed), $random(seed)};
            beats.push_back(b);
        end
        stream_burst("backpressure", 1'b1, 1'b0);
    endtask

    task automatic response_merge();
        resp_t     codes [6];
        narrow_r_t b;
        int        k;
        codes = '{`DWN_RESP_OKAY, `DWN_RESP_SLVERR, `DWN_RESP_DECERR,
                  `DWN_RESP_OKAY, `DWN_RESP_EXOKAY, `DWN_RESP_OKAY};
        beats.delete();
        for (k = 0; k < 6; k++)
        begin
            b      = known_beat(k, 6);
            b.resp = codes[k];
            beats.push_back(b);
        end
        stream_burst("merge", 1'b0, 1'b1);
    endtask

    // Watchdog
    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        seed           = 32'hdbee_ae77;
        cyc            = 0;
        checks         = 0;
        errors         = 0;
        sva_errors     = 0;
        rst_ni         = 1'b1;
        slv_ar_i       = '0;
        slv_ar_valid_i = 1'b0;
        slv_r_ready_i  = 1'b1;
        mst_ar_ready_i = 1'b0;
        mst_r_i        = '0;
        mst_r_valid_i  = 1'b0;
        // Clean falling edge for the asynchronous reset
        #5;
        rst_ni = 1'b0;
        repeat (8) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;

        reset_state();
        request_translation();
        gather_plain();
        slave_backpressure();
        response_merge();

        sva_errors = u_dut.u_chk.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, sva_errors);
        if (errors == 0 && sva_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
